//--- compile.f
src/aud_pkg.sv
src/aud_tick_timer.sv
src/aud_fetch_fsm.sv
src/aud_sample_fifo.sv
src/aud_channel_latch.sv
src/aud_stream_top.sv
testbench/tb_axil_mem.sv
testbench/tb_aud_stream.sv

//--- Bender.yml
package:
  name: aud_stream

sources:
  - src/aud_pkg.sv
  - src/aud_tick_timer.sv
  - src/aud_fetch_fsm.sv
  - src/aud_sample_fifo.sv
  - src/aud_channel_latch.sv
  - src/aud_stream_top.sv
  - target: test
    files:
      - testbench/tb_axil_mem.sv
      - testbench/tb_aud_stream.sv

//--- testbench/tb_aud_stream.sv
// Testbench for the aux audio stream, table driven with a reference model of the sample pairs
`default_nettype none

module tb_aud_stream import aud_pkg::*; ();

	localparam int                     TICK_DIV   = 20;
	localparam int                     BUF_WORDS  = 16;
	localparam logic [AXIL_ADDR_W-1:0] BASE_ADDR  = 32'h0004_0000;
	localparam int                     FIFO_DEPTH = 4;
	localparam int                     NUM_ROWS   = 6;
	localparam int                     HALF_BIT   = $clog2(BUF_WORDS) - 1;

	typedef struct packed {
		logic       ena;                        // Stream enable level
		logic [7:0] max_delay;                  // Memory wait bound
		logic [7:0] ticks;                      // Row length in ticks
		logic       under;                      // Underruns must grow
	} stim_row_t;

	logic       CLK_114;
	logic       rst_n;
	logic       ena;
	logic [7:0] max_delay;
	axil_ar_t   ar;
	logic       ar_valid;
	logic       ar_ready;
	axil_r_t    r;
	logic       r_valid;
	logic       r_ready;
	aud_pair_t  pair;
	logic       pair_valid;
	logic       buf_half;
	logic [7:0] underruns;

	stim_row_t  rows [NUM_ROWS];
	int         row;
	int         k;                              // Index of next left word
	int         ar_idx;                         // Index expected on AR
	int         r_idx;                          // Index of next R beat
	logic       exp_half;
	aud_pair_t  last_pair;                      // Outputs must hold this
	logic       outstanding;
	logic       ar_wait;                        // AR offered, not yet taken
	axil_ar_t   ar_prev;
	int         pairs_seen;
	int         value_errs;
	int         other_errs;
	int         cycles;
	int         limit;

	aud_stream_top #(
		.TICK_DIV   (TICK_DIV),
		.BUF_WORDS  (BUF_WORDS),
		.BASE_ADDR  (BASE_ADDR),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_dut (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.ena        (ena),
		.ar         (ar),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.r          (r),
		.r_valid    (r_valid),
		.r_ready    (r_ready),
		.pair       (pair),
		.pair_valid (pair_valid),
		.buf_half   (buf_half),
		.underruns  (underruns)
	);

	tb_axil_mem i_mem (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.max_delay  (max_delay),
		.ar         (ar),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.r          (r),
		.r_valid    (r_valid),
		.r_ready    (r_ready)
	);

	always #5 CLK_114 = ~CLK_114;

	// Memory word for buffer index, byte-swapped as the DAC sees it
	function automatic logic [SAMPLE_W-1:0] expect_sample(input int idx);
		logic [AXIL_ADDR_W-1:0] addr;
		logic [SAMPLE_W-1:0]    word;
		addr = BASE_ADDR + AXIL_ADDR_W'(2 * (idx % BUF_WORDS));
		word = addr[15:0] ^ 16'hA5C3;
		return {word[7:0], word[15:8]};
	endfunction

	task automatic compare_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Monitor, values seen just before each rising edge
	////////////////////////////////////////////////////////////////////////////

	always @(posedge CLK_114) begin
		if (rst_n) begin
			if (pair_valid) begin
				compare_hex("pair.left", pair.left, expect_sample(k));
				compare_hex("pair.right", pair.right, expect_sample(k + 1));
				k = (k + 2) % BUF_WORDS;        // Next pair of the walk
				last_pair = pair;
				pairs_seen++;
			end else begin
				compare_hex("pair", pair, last_pair); // Held between pairs
			end
			compare_hex("buf_half", buf_half, exp_half);
			if (ar_wait) begin
				assert (ar_valid && (ar == ar_prev)) else begin
					$display("AR request changed or dropped before ar_ready");
					other_errs++;
				end
			end
			assert (!r_ready || outstanding) else begin
				$display("r_ready high with no read outstanding");
				other_errs++;
			end
			if (ar_valid && ar_ready) begin
				if (ena) begin
					compare_hex("ar.addr", ar.addr, BASE_ADDR + AXIL_ADDR_W'(2 * ar_idx));
					ar_idx = (ar_idx + 1) % BUF_WORDS;
				end
				outstanding = 1'b1;
			end
			ar_wait = ar_valid && !ar_ready;
			ar_prev = ar;
			if (r_valid && r_ready) begin
				if (ena) begin
					exp_half = r_idx[HALF_BIT]; // Half of the word just taken
					r_idx    = (r_idx + 1) % BUF_WORDS;
				end
				outstanding = 1'b0;
			end
			if (!ena) begin
				k      = 0;                     // Rewind with the DUT
				ar_idx = 0;
				r_idx  = 0;
			end
		end
	end

	task automatic apply_row(input stim_row_t cfg);
		int base_under;
		int base_pairs;
		ena       = cfg.ena;
		max_delay = cfg.max_delay;
		repeat (2) @(negedge CLK_114);          // Let a boundary tick settle
		base_under = underruns;
		base_pairs = pairs_seen;
		repeat (int'(cfg.ticks) * TICK_DIV - 2) @(negedge CLK_114);
		if (cfg.under) begin
			assert (int'(underruns) > base_under) else begin
				$display("No underrun counted with slow memory");
				other_errs++;
			end
		end else begin
			compare_hex("underruns", underruns, base_under);
		end
		if (cfg.ena && !cfg.under) begin
			assert (pairs_seen - base_pairs >= int'(cfg.ticks) - 1) else begin
				$display("Only %0d pairs in %0d ticks", pairs_seen - base_pairs, cfg.ticks);
				other_errs++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus, inputs change on the falling edge
	////////////////////////////////////////////////////////////////////////////

	initial begin
		CLK_114     = 1'b0;
		rst_n       = 1'b0;
		ena         = 1'b0;
		max_delay   = 8'd0;
		k           = 0;
		ar_idx      = 0;
		r_idx       = 0;
		exp_half    = 1'b0;
		last_pair   = '0;
		outstanding = 1'b0;
		ar_wait     = 1'b0;
		ar_prev     = '0;
		pairs_seen  = 0;
		value_errs  = 0;
		other_errs  = 0;
		// ena, max delay, ticks, underrun expected
		rows[0] = '{1'b0, 8'd0, 8'd2, 1'b0};   // Idle after reset
		rows[1] = '{1'b1, 8'd1, 8'd20, 1'b0};  // Fast memory, wraps the buffer
		rows[2] = '{1'b1, 8'd3, 8'd24, 1'b0};  // Back-pressure on AR and R
		rows[3] = '{1'b1, 8'd30, 8'd12, 1'b1}; // Slower than a tick
		rows[4] = '{1'b0, 8'd2, 8'd4, 1'b0};   // Disable, flush and rewind
		rows[5] = '{1'b1, 8'd1, 8'd10, 1'b0};  // Restart from word 0
		limit = 0;
		for (row = 0; row < NUM_ROWS; row++) begin
			limit += int'(rows[row].ticks) * TICK_DIV + 200;
		end
		repeat (16) @(negedge CLK_114);
		rst_n = 1'b1;
		repeat (2) @(negedge CLK_114);
		compare_hex("ar_valid", ar_valid, 1'b0);
		compare_hex("r_ready", r_ready, 1'b0);
		compare_hex("pair_valid", pair_valid, 1'b0);
		compare_hex("buf_half", buf_half, 1'b0);
		compare_hex("pair", pair, 32'h0);
		compare_hex("underruns", underruns, 8'h00);
		for (row = 0; row < NUM_ROWS; row++) begin
			apply_row(rows[row]);
		end
		$display("Errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog over the whole run
	initial begin
		cycles = 0;
		while ((limit == 0) || (cycles < limit)) begin
			@(posedge CLK_114);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", limit);
		$display("Errors: %0d value, %0d other", value_errs, other_errs);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/tb_axil_mem.sv
// AXI4-Lite read-only memory model with random AR/R delays and an address-derived data pattern
`default_nettype none

module tb_axil_mem import aud_pkg::*; (
	input  wire        CLK_114,
	input  wire        rst_n,
	input  logic [7:0] max_delay,               // Upper bound of each random wait
	input  axil_ar_t   ar,
	input  logic       ar_valid,
	output logic       ar_ready,
	output axil_r_t    r,
	output logic       r_valid,
	input  logic       r_ready
);

	logic [7:0]             bound_q;            // Delay bound sampled on the rising edge
	logic [AXIL_ADDR_W-1:0] addr_q;             // Address of the read in service
	int unsigned            wait_cyc;

	// Sample pattern in the low half and the upper address in the high half
	function automatic axil_r_t read_beat(input logic [AXIL_ADDR_W-1:0] a);
		axil_r_t beat;
		beat.data = {a[31:16] ^ 16'h5A3C, a[15:0] ^ 16'hA5C3};
		beat.resp = 2'b00;                      // OKAY
		return beat;
	endfunction

	always @(posedge CLK_114) begin
		bound_q <= max_delay;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read server for one request at a time with outputs on the falling edge
	////////////////////////////////////////////////////////////////////////////

	initial begin
		ar_ready = 1'b0;
		r_valid  = 1'b0;
		r        = '0;
		void'($urandom(32'h14));                // Fixed seed for the whole run
		forever begin
			@(negedge CLK_114);
			if (rst_n && ar_valid) begin
				wait_cyc = $urandom % (int'(bound_q) + 1);
				repeat (wait_cyc) @(negedge CLK_114);
				addr_q   = ar.addr;             // AR held stable by the master
				ar_ready = 1'b1;
				@(negedge CLK_114);             // AR taken on the edge between
				ar_ready = 1'b0;
				wait_cyc = $urandom % (int'(bound_q) + 1);
				repeat (wait_cyc) @(negedge CLK_114);
				r       = read_beat(addr_q);
				r_valid = 1'b1;
				while (!r_ready) begin
					@(negedge CLK_114);         // Beat held until the master is ready
				end
				@(negedge CLK_114);             // Beat taken on the edge between
				r_valid = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/aud_stream_top.sv
// Streamed aux audio top, timer, AXI4-Lite fetcher, prefetch FIFO and channel latch
`default_nettype none

module aud_stream_top import aud_pkg::*; #(
	parameter int                     TICK_DIV   = 643,
	parameter int                     BUF_WORDS  = 32768,
	parameter logic [AXIL_ADDR_W-1:0] BASE_ADDR  = 32'h0004_0000,
	parameter int                     FIFO_DEPTH = 8
) (
	input  wire        CLK_114,
	input  wire        rst_n,
	input  logic       ena,                    // Stream on, low flushes and rewinds
	// AXI4-Lite read master
	output axil_ar_t   ar,
	output logic       ar_valid,
	input  logic       ar_ready,
	input  axil_r_t    r,
	input  logic       r_valid,
	output logic       r_ready,
	// Audio side
	output aud_pair_t  pair,
	output logic       pair_valid,
	output logic       buf_half,               // Host double-buffer flag
	output logic [7:0] underruns
);

	localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

	////////////////////////////////////////////////////////////////////////////
	// Internal wiring
	////////////////////////////////////////////////////////////////////////////

	logic                tick;
	logic [CNT_W-1:0]    fifo_count;
	logic                push;
	logic [SAMPLE_W-1:0] push_data;
	logic                pop;
	logic [SAMPLE_W-1:0] pop_data;

	aud_tick_timer #(
		.TICK_DIV   (TICK_DIV)
	) i_timer (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.ena        (ena),
		.tick       (tick)
	);

	aud_fetch_fsm #(
		.BUF_WORDS  (BUF_WORDS),
		.BASE_ADDR  (BASE_ADDR),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_fetch (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.ena        (ena),
		.fifo_count (fifo_count),
		.ar         (ar),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.r          (r),
		.r_valid    (r_valid),
		.r_ready    (r_ready),
		.push       (push),
		.push_data  (push_data),
		.buf_half   (buf_half)
	);

	aud_sample_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_fifo (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.flush      (~ena),                    // Disabled stream keeps nothing
		.push       (push),
		.push_data  (push_data),
		.pop        (pop),
		.pop_data   (pop_data),
		.count      (fifo_count)
	);

	aud_channel_latch #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_latch (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.tick       (tick),
		.fifo_count (fifo_count),
		.pop        (pop),
		.pop_data   (pop_data),
		.pair       (pair),
		.pair_valid (pair_valid),
		.underruns  (underruns)
	);

endmodule

`default_nettype wire

//--- src/aud_channel_latch.sv
// Channel latch, pops left/right per tick, byte-swaps them and counts underruns
`default_nettype none

module aud_channel_latch import aud_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  wire                             CLK_114,
	input  wire                             rst_n,
	input  logic                            tick,
	input  logic [$clog2(FIFO_DEPTH):0]     fifo_count,
	output logic                            pop,
	input  logic [SAMPLE_W-1:0]             pop_data,
	output aud_pair_t                       pair,
	output logic                            pair_valid,
	output logic [7:0]                      underruns
);

	localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

	logic                have_pair;            // Both words present at tick
	logic                second;               // Right word pops this cycle
	logic                take_right;
	logic [SAMPLE_W-1:0] left_q;               // Left staged until right arrives

	// Memory words are big-endian relative to the DAC
	function automatic logic [SAMPLE_W-1:0] swap_bytes(input logic [SAMPLE_W-1:0] w);
		return {w[7:0], w[15:8]};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Pop sequence
	////////////////////////////////////////////////////////////////////////////

	assign have_pair  = (fifo_count >= CNT_W'(2));
	assign take_right = second && (fifo_count != '0); // Skipped if FIFO was flushed
	assign pop        = (tick && have_pair) || take_right;

	always_ff @(posedge CLK_114) begin
		if (tick && have_pair) begin
			left_q <= swap_bytes(pop_data);    // Left in tick cycle
		end
	end

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			second     <= 1'b0;
			pair       <= '0;
			pair_valid <= 1'b0;
			underruns  <= '0;
		end else begin
			second     <= tick && have_pair;
			pair_valid <= 1'b0;
			if (tick && !have_pair && (underruns != 8'hFF)) begin
				underruns <= underruns + 1'b1; // Sticky, saturates at 255
			end
			if (take_right) begin
				pair.left  <= left_q;          // Both channels change together
				pair.right <= swap_bytes(pop_data);
				pair_valid <= 1'b1;            // Two cycles after tick
			end
		end
	end

endmodule

`default_nettype wire

//--- src/aud_sample_fifo.sv
// Prefetch FIFO of sample words, head visible on pop_data, with fill count and flush
`default_nettype none

module aud_sample_fifo import aud_pkg::*; #(
	parameter int FIFO_DEPTH = 8               // Power of two, at least 4
) (
	input  wire                             CLK_114,
	input  wire                             rst_n,
	input  logic                            flush,
	input  logic                            push,
	input  logic [SAMPLE_W-1:0]             push_data,
	input  logic                            pop,
	output logic [SAMPLE_W-1:0]             pop_data,
	output logic [$clog2(FIFO_DEPTH):0]     count
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	logic [SAMPLE_W-1:0] mem [FIFO_DEPTH];     // Sample storage
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic                wr_en;
	logic                rd_en;

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	assign wr_en = push && !flush && (count != CNT_W'(FIFO_DEPTH)); // Drop on full
	assign rd_en = pop && !flush && (count != '0);                  // Ignore on empty

	always_ff @(posedge CLK_114) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_data;
		end
	end

	assign pop_data = mem[rd_ptr];             // Head word, read with the pop

	////////////////////////////////////////////////////////////////////////////
	// Pointers and fill count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;                      // Empty in one cycle
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;       // Natural wrap
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(wr_en) - CNT_W'(rd_en); // Seen next cycle
		end
	end

endmodule

`default_nettype wire

//--- src/aud_fetch_fsm.sv
// Sample fetcher, walks the circular buffer with single AXI4-Lite reads into the FIFO
`default_nettype none

module aud_fetch_fsm import aud_pkg::*; #(
	parameter int                     BUF_WORDS  = 32768,
	parameter logic [AXIL_ADDR_W-1:0] BASE_ADDR  = 32'h0004_0000,
	parameter int                     FIFO_DEPTH = 8
) (
	input  wire                             CLK_114,
	input  wire                             rst_n,
	input  logic                            ena,
	input  logic [$clog2(FIFO_DEPTH):0]     fifo_count,
	output axil_ar_t                        ar,
	output logic                            ar_valid,
	input  logic                            ar_ready,
	input  axil_r_t                         r,
	input  logic                            r_valid,
	output logic                            r_ready,
	output logic                            push,
	output logic [SAMPLE_W-1:0]             push_data,
	output logic                            buf_half
);

	localparam int IDX_W = $clog2(BUF_WORDS);
	localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

	typedef enum logic [1:0] {
		ST_IDLE,                               // No read outstanding
		ST_ADDR,                               // AR offered, waiting for ar_ready
		ST_DATA                                // Waiting for R beat
	} fetch_state_t;

	fetch_state_t     state;
	logic [IDX_W-1:0] idx;                     // Buffer index of next word
	logic             drop;                    // Outstanding read was cancelled
	logic             issue;
	axil_ar_t         ar_q;                    // Held stable until AR handshake

	////////////////////////////////////////////////////////////////////////////
	// Read issue and handshakes
	////////////////////////////////////////////////////////////////////////////

	// Only one read in flight, so a free slot now still frees when R returns
	assign issue    = ena && (state == ST_IDLE) && (fifo_count < CNT_W'(FIFO_DEPTH));
	assign ar       = ar_q;
	assign ar_valid = (state == ST_ADDR);
	assign r_ready  = (state == ST_DATA);   // Only while outstanding

	// Accepted beat goes to FIFO unless disabled meanwhile
	assign push      = r_valid && r_ready && ena && !drop;
	assign push_data = r.data[SAMPLE_W-1:0]; // Sample in low half

	always_ff @(posedge CLK_114) begin
		if (issue) begin
			ar_q.addr <= BASE_ADDR + AXIL_ADDR_W'({idx, 1'b0}); // Word to byte address
			ar_q.prot <= 3'b000;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// State, index and buffer half
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			idx      <= '0;
			drop     <= 1'b0;
			buf_half <= 1'b0;
		end else begin
			if (!ena) begin
				idx <= '0;                     // Restart buffer walk
			end
			case (state)
				ST_IDLE: begin
					if (issue) begin
						state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (!ena) begin
						drop <= 1'b1;          // AR must still complete
					end
					if (ar_ready) begin
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (!ena) begin
						drop <= 1'b1;
					end
					if (r_valid) begin
						state <= ST_IDLE;
						drop  <= 1'b0;         // Beat consumed or discarded
					end
				end
				default: state <= ST_IDLE;
			endcase
			if (push) begin
				buf_half <= idx[IDX_W-1];      // Half of word just taken
				idx      <= idx + 1'b1;        // Wraps at BUF_WORDS
			end
		end
	end

endmodule

`default_nettype wire

//--- src/aud_tick_timer.sv
// Sample tick timer, one-cycle pulse every TICK_DIV clocks while enabled
`default_nettype none

module aud_tick_timer #(
	parameter int TICK_DIV = 643                // Clocks per sample tick
) (
	input  wire  CLK_114,
	input  wire  rst_n,
	input  logic ena,                          // Run / hold at zero
	output logic tick                          // One-cycle sample strobe
);

	////////////////////////////////////////////////////////////////////////////
	// Period counter
	////////////////////////////////////////////////////////////////////////////

	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [CNT_W-1:0] cnt;                     // Cycles into current period
	logic             wrap;                    // Last cycle of period

	assign wrap = (cnt == CNT_W'(TICK_DIV - 1));

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else if (!ena) begin
			cnt  <= '0;                        // Restart period on next enable
			tick <= 1'b0;
		end else begin
			tick <= wrap;                      // Lands TICK_DIV cycles after ena
			if (wrap) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/aud_pkg.sv
// Aux audio stream package with memory port widths, AXI4-Lite read structs and the sample pair
`default_nettype none

package aud_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Fixed widths
	////////////////////////////////////////////////////////////////////////////

	localparam int AXIL_ADDR_W = 32;           // Byte address of memory port
	localparam int AXIL_DATA_W = 32;           // Read data, sample in low half
	localparam int SAMPLE_W    = 16;           // One audio sample

	////////////////////////////////////////////////////////////////////////////
	// AXI4-Lite read channels
	////////////////////////////////////////////////////////////////////////////

	// AR payload, valid/ready travel beside it
	typedef struct packed {
		logic [AXIL_ADDR_W-1:0] addr;          // Byte address
		logic [2:0]             prot;          // Protection, always data/secure/unpriv
	} axil_ar_t;

	// R payload
	typedef struct packed {
		logic [AXIL_DATA_W-1:0] data;          // Read word
		logic [1:0]             resp;          // OKAY expected
	} axil_r_t;

	////////////////////////////////////////////////////////////////////////////
	// Output sample pair
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [SAMPLE_W-1:0] left;             // First word of the tick
		logic [SAMPLE_W-1:0] right;            // Second word of the tick
	} aud_pair_t;

endpackage

`default_nettype wire
